/* rtl/fdc_pkg.sv */
/*
 * fdc_pkg: shared definitions for the WD279x-style floppy controller.
 * Register map, step-rate table, command classes and FSM state types.
 */
package fdc_pkg;

	// host register addresses
	localparam logic [1:0] A_CMD_STAT = 2'd0;
	localparam logic [1:0] A_TRACK    = 2'd1;
	localparam logic [1:0] A_SECTOR   = 2'd2;
	localparam logic [1:0] A_DATA     = 2'd3;

	// step interval in ms ticks, indexed by rate code
	localparam logic [3:0][4:0] STEP_MS_TABLE = {5'd30, 5'd20, 5'd12, 5'd6};

	// restore gives up after this many steps
	localparam logic [7:0] MAX_STEPS = 8'd255;

	// index pulses before record-not-found
	localparam logic [2:0] RNF_INDEX_COUNT = 3'd5;

	// decoded from command bits 7..4
	typedef enum logic [2:0] {
		CMD_RESTORE,
		CMD_SEEK,
		CMD_READ,
		CMD_FORCE,
		CMD_NONE
	} cmd_class_t;

	typedef struct packed {
		cmd_class_t cls;
		logic [1:0] rate;
		logic       imm_int;
	} fdc_cmd_t;

	// sector ID field as seen from the drive side
	typedef struct packed {
		logic [7:0] track;
		logic       side;
		logic [7:0] sector;
		logic [1:0] size;
	} fdc_sec_id_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_DECIDE,
		S_PULSE,
		S_WAIT,
		S_DONE
	} seek_state_t;

	typedef enum logic [1:0] {
		R_IDLE,
		R_SEARCH,
		R_XFER,
		R_DONE
	} rd_state_t;

endpackage

/* rtl/fdc_host_regs.sv */
/*
 * fdc_host_regs: host side of the controller. Strobe edge detection,
 * command/track/sector/data registers, command decode and read-back mux.
 */
`timescale 1ns/1ps

module fdc_host_regs import fdc_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       cs_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	input  logic [7:0] stat_i,
	input  logic [7:0] stat_ii,
	input  logic       busy_i,
	input  logic       busy_ii,
	input  logic [7:0] track_out,
	input  logic       track_wr,
	input  logic [7:0] rd_byte,
	input  logic       byte_wr,
	output logic [7:0] dout,
	output fdc_cmd_t   cmd,
	output logic       cmd_start,
	output logic       data_rd,
	output logic       stat_rd,
	output logic [7:0] track,
	output logic [7:0] sector,
	output logic [7:0] data
);

	logic       wr_prev;
	logic       rd_prev;
	logic       wr_edge;
	logic       rd_edge;
	logic       pending;
	logic       busy;
	logic [7:0] status;
	cmd_class_t din_cls;

	// class of the byte on din
	always_comb begin
		case (din[7:4])
			4'h0:    din_cls = CMD_RESTORE;
			4'h1:    din_cls = CMD_SEEK;
			4'h8:    din_cls = CMD_READ;
			4'hD:    din_cls = CMD_FORCE;
			default: din_cls = CMD_NONE;
		endcase
	end

	// previous strobe samples, idle high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_prev <= 1'b1;
			rd_prev <= 1'b1;
		end else begin
			wr_prev <= wr_n;
			rd_prev <= rd_n;
		end
	end

	assign wr_edge = !cs_n && !wr_n && wr_prev;
	assign rd_edge = !cs_n && !rd_n && rd_prev;
	assign data_rd = rd_edge && (addr == A_DATA);
	assign stat_rd = rd_edge && (addr == A_CMD_STAT);

	// covers the start cycle, before the owning block raises its busy
	assign pending = cmd_start && (cmd.cls inside {CMD_RESTORE, CMD_SEEK, CMD_READ});
	assign busy    = busy_i || busy_ii || pending;

	// command register and start pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd       <= '{cls: CMD_NONE, rate: 2'b00, imm_int: 1'b0};
			cmd_start <= 1'b0;
		end else begin
			cmd_start <= 1'b0;
			// force interrupt always gets through
			if (wr_edge && addr == A_CMD_STAT && (!busy || din_cls == CMD_FORCE)) begin
				cmd       <= '{cls: din_cls, rate: din[1:0], imm_int: din[3]};
				cmd_start <= 1'b1;
			end
		end
	end

	// track, sector, data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			track  <= 8'd0;
			sector <= 8'd1;
			data   <= 8'd0;
		end else begin
			// seek machine wins over the host
			if (track_wr)
				track <= track_out;
			else if (wr_edge && addr == A_TRACK && !busy)
				track <= din;
			if (wr_edge && addr == A_SECTOR && !busy)
				sector <= din;
			// disk bytes override a host write
			if (byte_wr)
				data <= rd_byte;
			else if (wr_edge && addr == A_DATA)
				data <= din;
		end
	end

	// status by class of the last command
	always_comb begin
		case (cmd.cls)
			CMD_READ: status = stat_ii;
			CMD_NONE: status = 8'h00;
			default:  status = stat_i;
		endcase
		status[0] = status[0] | pending;
	end

	always_comb begin
		dout = 8'hFF;
		if (!cs_n && !rd_n) begin
			case (addr)
				A_CMD_STAT: dout = status;
				A_TRACK:    dout = track;
				A_SECTOR:   dout = sector;
				default:    dout = data;
			endcase
		end
	end

endmodule

/* rtl/fdc_step_timer.sv */
/*
 * fdc_step_timer: counts ms ticks for one step interval and
 * pulses expired when the interval for the selected rate is over.
 */
`timescale 1ns/1ps

module fdc_step_timer import fdc_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	input  logic [1:0] rate,
	input  logic       ms_tick,
	output logic       expired
);

	// remaining ticks, zero when idle
	logic [4:0] count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count   <= 5'd0;
			expired <= 1'b0;
		end else begin
			expired <= 1'b0;
			if (start) begin
				// restart even if still running
				count <= STEP_MS_TABLE[rate];
			end else if (ms_tick && count != 5'd0) begin
				count <= count - 5'd1;
				// last tick of the interval
				if (count == 5'd1)
					expired <= 1'b1;
			end
		end
	end

endmodule

/* rtl/fdc_seek_fsm.sv */
/*
 * fdc_seek_fsm: type I commands, restore and seek. Issues step pulses
 * paced by the step timer, updates the track register, builds type I status.
 */
`timescale 1ns/1ps

module fdc_seek_fsm import fdc_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  fdc_cmd_t   cmd,
	input  logic       cmd_start,
	input  logic       abort,
	input  logic [7:0] track,
	input  logic [7:0] data,
	input  logic       trk00_n,
	input  logic       index_n,
	input  logic       timer_expired,
	output logic       timer_start,
	output logic       step_n,
	output logic       dir_n,
	output logic [7:0] track_out,
	output logic       track_wr,
	output logic       busy,
	output logic [7:0] stat,
	output logic       done
);

	seek_state_t state;
	logic [7:0]  step_cnt;
	logic        seek_err;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= S_IDLE;
			step_cnt    <= 8'd0;
			seek_err    <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
			step_n      <= 1'b1;
			dir_n       <= 1'b1;
			track_out   <= 8'd0;
			track_wr    <= 1'b0;
			timer_start <= 1'b0;
		end else begin
			// single-cycle strobes
			step_n      <= 1'b1;
			track_wr    <= 1'b0;
			timer_start <= 1'b0;
			done        <= 1'b0;
			if (abort) begin
				state <= S_IDLE;
				busy  <= 1'b0;
			end else begin
				case (state)
					S_IDLE: begin
						if (cmd_start && (cmd.cls == CMD_RESTORE || cmd.cls == CMD_SEEK)) begin
							busy     <= 1'b1;
							seek_err <= 1'b0;
							step_cnt <= 8'd0;
							state    <= S_DECIDE;
						end
					end
					S_DECIDE: begin
						if (cmd.cls == CMD_RESTORE) begin
							if (!trk00_n) begin
								track_out <= 8'd0;
								track_wr  <= 1'b1;
								state     <= S_DONE;
							end else if (step_cnt == MAX_STEPS) begin
								seek_err <= 1'b1;
								state    <= S_DONE;
							end else begin
								// out toward track 0
								dir_n <= 1'b1;
								state <= S_PULSE;
							end
						end else if (track == data) begin
							state <= S_DONE;
						end else begin
							// low means in, toward higher tracks
							dir_n <= (data < track);
							state <= S_PULSE;
						end
					end
					S_PULSE: begin
						// dir_n settled one cycle ago
						step_n      <= 1'b0;
						timer_start <= 1'b1;
						step_cnt    <= step_cnt + 8'd1;
						if (cmd.cls == CMD_SEEK) begin
							track_out <= dir_n ? track - 8'd1 : track + 8'd1;
							track_wr  <= 1'b1;
						end
						state <= S_WAIT;
					end
					S_WAIT: begin
						if (timer_expired)
							state <= S_DECIDE;
					end
					default: begin
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= S_IDLE;
					end
				endcase
			end
		end
	end

	// seek error, track 0, index, busy
	assign stat = {3'b000, seek_err, 1'b0, !trk00_n, !index_n, busy};

endmodule

/* rtl/fdc_read_path.sv */
/*
 * fdc_read_path: type II read sector. Waits for a matching ID, hands the
 * sector bytes to the data register with DRQ and lost data, or times out as RNF.
 */
`timescale 1ns/1ps

module fdc_read_path import fdc_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  fdc_cmd_t    cmd,
	input  logic        cmd_start,
	input  logic        abort,
	input  logic [7:0]  track,
	input  logic [7:0]  sector,
	input  logic        index_n,
	input  logic        id_valid,
	input  fdc_sec_id_t id,
	input  logic        byte_valid,
	input  logic [7:0]  byte_in,
	input  logic        data_rd,
	output logic [7:0]  rd_byte,
	output logic        byte_wr,
	output logic        drq,
	output logic        busy,
	output logic [7:0]  stat,
	output logic        done
);

	rd_state_t   state;
	logic [10:0] byte_left;
	logic [2:0]  idx_cnt;
	logic        idx_prev;
	logic        rnf;
	logic        lost;
	logic        idx_fall;

	assign idx_fall = idx_prev && !index_n;

	// bytes go straight into the data register
	assign rd_byte = byte_in;
	assign byte_wr = (state == R_XFER) && byte_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= R_IDLE;
			byte_left <= 11'd0;
			idx_cnt   <= 3'd0;
			idx_prev  <= 1'b1;
			rnf       <= 1'b0;
			lost      <= 1'b0;
			drq       <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
		end else begin
			idx_prev <= index_n;
			done     <= 1'b0;
			// host read clears drq, a new byte sets it again
			if (data_rd)
				drq <= 1'b0;
			if (abort) begin
				state <= R_IDLE;
				busy  <= 1'b0;
				drq   <= 1'b0;
			end else begin
				case (state)
					R_IDLE: begin
						if (cmd_start && cmd.cls == CMD_READ) begin
							busy    <= 1'b1;
							rnf     <= 1'b0;
							lost    <= 1'b0;
							drq     <= 1'b0;
							idx_cnt <= 3'd0;
							state   <= R_SEARCH;
						end
					end
					R_SEARCH: begin
						if (id_valid && id.track == track && id.sector == sector) begin
							byte_left <= 11'd128 << id.size;
							state     <= R_XFER;
						end else if (idx_fall) begin
							if (idx_cnt == RNF_INDEX_COUNT - 3'd1) begin
								rnf   <= 1'b1;
								state <= R_DONE;
							end else begin
								idx_cnt <= idx_cnt + 3'd1;
							end
						end
					end
					R_XFER: begin
						if (byte_valid) begin
							// previous byte never taken
							if (drq && !data_rd)
								lost <= 1'b1;
							drq       <= 1'b1;
							byte_left <= byte_left - 11'd1;
							if (byte_left == 11'd1)
								state <= R_DONE;
						end
					end
					default: begin
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= R_IDLE;
					end
				endcase
			end
		end
	end

	// rnf, lost data, drq, busy
	assign stat = {3'b000, rnf, 1'b0, lost, drq, busy};

endmodule

/* rtl/fdc_top.sv */
/*
 * fdc_top: floppy controller top. Host registers, step timer,
 * type I seek machine and type II read path, plus INTRQ and force interrupt.
 */
`timescale 1ns/1ps

module fdc_top import fdc_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        cs_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [1:0]  addr,
	input  logic [7:0]  din,
	input  logic        ms_tick,
	input  logic        trk00_n,
	input  logic        index_n,
	input  logic        id_valid,
	input  fdc_sec_id_t id,
	input  logic        byte_valid,
	input  logic [7:0]  byte_in,
	output logic [7:0]  dout,
	output logic        drq,
	output logic        intrq,
	output logic        step_n,
	output logic        dir_n
);

	fdc_cmd_t   cmd;
	logic       cmd_start;
	logic       data_rd;
	logic       stat_rd;
	logic [7:0] track;
	logic [7:0] sector;
	logic [7:0] data;
	logic [7:0] stat_i;
	logic [7:0] stat_ii;
	logic       busy_i;
	logic       busy_ii;
	logic       done_i;
	logic       done_ii;
	logic [7:0] track_out;
	logic       track_wr;
	logic [7:0] rd_byte;
	logic       byte_wr;
	logic       timer_start;
	logic       timer_expired;
	logic       abort;
	logic       int_set;

	// force interrupt stops whatever runs
	assign abort   = cmd_start && cmd.cls == CMD_FORCE;
	assign int_set = done_i || done_ii || (abort && cmd.imm_int);

	// set wins over clear
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			intrq <= 1'b0;
		else if (int_set)
			intrq <= 1'b1;
		else if (stat_rd || cmd_start)
			intrq <= 1'b0;
	end

	fdc_host_regs u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.cs_n      (cs_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.addr      (addr),
		.din       (din),
		.stat_i    (stat_i),
		.stat_ii   (stat_ii),
		.busy_i    (busy_i),
		.busy_ii   (busy_ii),
		.track_out (track_out),
		.track_wr  (track_wr),
		.rd_byte   (rd_byte),
		.byte_wr   (byte_wr),
		.dout      (dout),
		.cmd       (cmd),
		.cmd_start (cmd_start),
		.data_rd   (data_rd),
		.stat_rd   (stat_rd),
		.track     (track),
		.sector    (sector),
		.data      (data)
	);

	fdc_step_timer u_timer (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (timer_start),
		.rate    (cmd.rate),
		.ms_tick (ms_tick),
		.expired (timer_expired)
	);

	fdc_seek_fsm u_seek (
		.clk           (clk),
		.arst_n        (arst_n),
		.cmd           (cmd),
		.cmd_start     (cmd_start),
		.abort         (abort),
		.track         (track),
		.data          (data),
		.trk00_n       (trk00_n),
		.index_n       (index_n),
		.timer_expired (timer_expired),
		.timer_start   (timer_start),
		.step_n        (step_n),
		.dir_n         (dir_n),
		.track_out     (track_out),
		.track_wr      (track_wr),
		.busy          (busy_i),
		.stat          (stat_i),
		.done          (done_i)
	);

	fdc_read_path u_read (
		.clk        (clk),
		.arst_n     (arst_n),
		.cmd        (cmd),
		.cmd_start  (cmd_start),
		.abort      (abort),
		.track      (track),
		.sector     (sector),
		.index_n    (index_n),
		.id_valid   (id_valid),
		.id         (id),
		.byte_valid (byte_valid),
		.byte_in    (byte_in),
		.data_rd    (data_rd),
		.rd_byte    (rd_byte),
		.byte_wr    (byte_wr),
		.drq        (drq),
		.busy       (busy_ii),
		.stat       (stat_ii),
		.done       (done_ii)
	);

endmodule

/* bench/fdc_tb.sv */
/*
 * fdc_tb: testbench for the floppy controller. Drive model with head position,
 * index and ms tick, host strobe tasks and a stimulus table run in a loop.
 */
`timescale 1ns/1ps

module fdc_tb import fdc_pkg::*; ();

	localparam int INDEX_PERIOD = 200;
	localparam int SECTOR_BYTES = 128;
	// longest restore twice over, plus RNF wait and one sector
	localparam int TIMEOUT_CYCLES =
		2 * (int'(MAX_STEPS) * 31 * 4 + int'(RNF_INDEX_COUNT) * INDEX_PERIOD + SECTOR_BYTES * 3);

	typedef enum logic [3:0] {
		OP_WR,
		OP_RD,
		OP_RDHEAD,
		OP_INTRQ,
		OP_DRQ,
		OP_WAIT_INT,
		OP_IDLE,
		OP_CLR,
		OP_STEPS,
		OP_GAP,
		OP_STREAM,
		OP_END
	} op_t;

	// one table row; stream uses addr as mode, val as sector, exp as track
	typedef struct packed {
		op_t        op;
		logic [1:0] addr;
		logic [7:0] val;
		logic [7:0] exp;
		logic [7:0] mask;
	} row_t;

	logic        clk;
	logic        arst_n;
	logic        cs_n;
	logic        rd_n;
	logic        wr_n;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic        ms_tick;
	logic        trk00_n;
	logic        index_n;
	logic        id_valid;
	fdc_sec_id_t id;
	logic        byte_valid;
	logic [7:0]  byte_in;
	logic [7:0]  dout;
	logic        drq;
	logic        intrq;
	logic        step_n;
	logic        dir_n;

	row_t       rows [0:79];
	int         n_rows;
	string      test_name [0:7];
	logic [7:0] sect_buf [0:SECTOR_BYTES-1];
	integer     seed;
	int         cycle_cnt;
	int         err_total;
	int         test_err;
	int         tests_failed;

	// drive model state
	int   div_cnt;
	int   head_pos;
	int   in_cnt;
	int   out_cnt;
	int   tick_gap;
	int   min_gap;
	logic stuck;

	fdc_top uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.cs_n       (cs_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.addr       (addr),
		.din        (din),
		.ms_tick    (ms_tick),
		.trk00_n    (trk00_n),
		.index_n    (index_n),
		.id_valid   (id_valid),
		.id         (id),
		.byte_valid (byte_valid),
		.byte_in    (byte_in),
		.dout       (dout),
		.drq        (drq),
		.intrq      (intrq),
		.step_n     (step_n),
		.dir_n      (dir_n)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// drive side, all on the falling edge
	always @(negedge clk) begin
		div_cnt = div_cnt + 1;
		if (!step_n) begin
			// dir_n low steps in
			if (dir_n) begin
				out_cnt = out_cnt + 1;
				if (head_pos != 0)
					head_pos = head_pos - 1;
			end else begin
				in_cnt = in_cnt + 1;
				head_pos = head_pos + 1;
			end
			if (in_cnt + out_cnt > 1 && tick_gap < min_gap)
				min_gap = tick_gap;
			tick_gap = 0;
		end
		ms_tick = (div_cnt % 4 == 0);
		if (ms_tick && step_n)
			tick_gap = tick_gap + 1;
		// short low pulse once per revolution
		index_n = !((div_cnt % INDEX_PERIOD) < 4);
		trk00_n = !(head_pos == 0 && !stuck);
	end

	// hard stop
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt = cycle_cnt + 1;
		end
		$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	function automatic string reg_name(input logic [1:0] a);
		case (a)
			A_CMD_STAT: return "status";
			A_TRACK:    return "track";
			A_SECTOR:   return "sector";
			default:    return "data";
		endcase
	endfunction

	task automatic report_mismatch(input string sig, input logic [7:0] expv, input logic [7:0] act);
		$display("[FAIL] %0t ns %s: expected %h, got %h", $time, sig, expv, act);
		err_total = err_total + 1;
		test_err = test_err + 1;
	endtask

	task automatic add_row(input op_t op, input logic [1:0] a, input logic [7:0] v,
			input logic [7:0] e, input logic [7:0] m);
		rows[n_rows] = '{op: op, addr: a, val: v, exp: e, mask: m};
		n_rows = n_rows + 1;
	endtask

	task automatic host_write(input logic [1:0] a, input logic [7:0] d);
		@(negedge clk);
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = a;
		din  = d;
		@(negedge clk);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic host_read(input logic [1:0] a, output logic [7:0] d);
		@(negedge clk);
		cs_n = 1'b0;
		rd_n = 1'b0;
		addr = a;
		// dout settled half a cycle after the edge
		@(negedge clk);
		d    = dout;
		cs_n = 1'b1;
		rd_n = 1'b1;
	endtask

	// mode 0 reads every byte, 1 skips the first read, 2 sends the ID only
	task automatic stream_sector(input logic [1:0] mode, input logic [7:0] sec,
			input logic [7:0] trk);
		int         i;
		int         rnd;
		logic [7:0] got;
		@(negedge clk);
		id_valid  = 1'b1;
		id.track  = trk;
		id.side   = 1'b0;
		id.sector = sec;
		id.size   = 2'd0;
		@(negedge clk);
		id_valid = 1'b0;
		if (mode != 2'd2) begin
			for (i = 0; i < SECTOR_BYTES; i++) begin
				rnd = $random(seed);
				sect_buf[i] = rnd[7:0];
				@(negedge clk);
				byte_valid = 1'b1;
				byte_in    = sect_buf[i];
				@(negedge clk);
				byte_valid = 1'b0;
				if (drq !== 1'b1)
					report_mismatch("drq", 8'h01, {7'd0, drq});
				// lost data case holds back the first read
				if (!(mode == 2'd1 && i == 0)) begin
					cs_n = 1'b0;
					rd_n = 1'b0;
					addr = A_DATA;
				end
				@(negedge clk);
				got  = dout;
				if (!(mode == 2'd1 && i == 0) && got !== sect_buf[i])
					report_mismatch("data", sect_buf[i], got);
				cs_n = 1'b1;
				rd_n = 1'b1;
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [7:0] got;
		int         cnt;
		case (r.op)
			OP_WR: host_write(r.addr, r.val);
			OP_RD: begin
				host_read(r.addr, got);
				if ((got & r.mask) !== r.exp)
					report_mismatch(reg_name(r.addr), r.exp, got & r.mask);
			end
			OP_RDHEAD: begin
				host_read(r.addr, got);
				// track register follows the head, one step per pulse
				if (got !== head_pos[7:0])
					report_mismatch(reg_name(r.addr), head_pos[7:0], got);
			end
			OP_INTRQ: begin
				@(negedge clk);
				if (intrq !== r.exp[0])
					report_mismatch("intrq", r.exp, {7'd0, intrq});
			end
			OP_DRQ: begin
				@(negedge clk);
				if (drq !== r.exp[0])
					report_mismatch("drq", r.exp, {7'd0, drq});
			end
			OP_WAIT_INT: begin
				while (intrq !== 1'b1)
					@(negedge clk);
			end
			OP_IDLE: repeat (r.val) @(negedge clk);
			OP_CLR: begin
				in_cnt  = 0;
				out_cnt = 0;
				min_gap = 255;
				stuck   = r.addr[0];
			end
			OP_STEPS: begin
				cnt = r.addr[0] ? out_cnt : in_cnt;
				if (cnt != int'(r.exp))
					report_mismatch(r.addr[0] ? "step_n out pulses" : "step_n in pulses",
						r.exp, cnt[7:0]);
			end
			OP_GAP: begin
				if (min_gap < int'(r.exp))
					report_mismatch("step_n gap in ms ticks", r.exp, min_gap[7:0]);
			end
			OP_STREAM: stream_sector(r.addr, r.val, r.exp);
			default: begin
				if (test_err == 0) begin
					$display("test %0d %s: ok", r.val, test_name[r.val]);
				end else begin
					$display("test %0d %s: %0d errors", r.val, test_name[r.val], test_err);
					tests_failed = tests_failed + 1;
				end
				test_err = 0;
			end
		endcase
	endtask

	task automatic build_table();
		// reset defaults
		add_row(OP_RD, A_TRACK, 8'h00, 8'h00, 8'hFF);
		add_row(OP_RD, A_SECTOR, 8'h00, 8'h01, 8'hFF);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h00, 8'hFF);
		add_row(OP_INTRQ, 2'd0, 8'h00, 8'h00, 8'hFF);
		add_row(OP_DRQ, 2'd0, 8'h00, 8'h00, 8'hFF);
		add_row(OP_END, 2'd0, 8'd0, 8'h00, 8'h00);
		// seek 0 to 5 at rate 0
		add_row(OP_CLR, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_WR, A_DATA, 8'd5, 8'h00, 8'h00);
		add_row(OP_WR, A_CMD_STAT, 8'h10, 8'h00, 8'h00);
		add_row(OP_WAIT_INT, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_STEPS, 2'd0, 8'h00, 8'd5, 8'h00);
		add_row(OP_STEPS, 2'd1, 8'h00, 8'd0, 8'h00);
		add_row(OP_GAP, 2'd0, 8'h00, 8'(STEP_MS_TABLE[0]), 8'h00);
		add_row(OP_INTRQ, 2'd0, 8'h00, 8'h01, 8'hFF);
		add_row(OP_RD, A_TRACK, 8'h00, 8'd5, 8'hFF);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h00, 8'h01);
		add_row(OP_INTRQ, 2'd0, 8'h00, 8'h00, 8'hFF);
		add_row(OP_END, 2'd0, 8'd1, 8'h00, 8'h00);
		// restore from track 5
		add_row(OP_CLR, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_WR, A_CMD_STAT, 8'h00, 8'h00, 8'h00);
		add_row(OP_WAIT_INT, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_STEPS, 2'd1, 8'h00, 8'd5, 8'h00);
		add_row(OP_STEPS, 2'd0, 8'h00, 8'd0, 8'h00);
		add_row(OP_RD, A_TRACK, 8'h00, 8'h00, 8'hFF);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h04, 8'h14);
		add_row(OP_END, 2'd0, 8'd2, 8'h00, 8'h00);
		// restore with track 0 never seen
		add_row(OP_CLR, 2'd1, 8'h00, 8'h00, 8'h00);
		add_row(OP_WR, A_CMD_STAT, 8'h00, 8'h00, 8'h00);
		add_row(OP_WAIT_INT, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_STEPS, 2'd1, 8'h00, MAX_STEPS, 8'h00);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h10, 8'h10);
		add_row(OP_CLR, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_END, 2'd0, 8'd3, 8'h00, 8'h00);
		// read track 0 sector 3
		add_row(OP_WR, A_SECTOR, 8'd3, 8'h00, 8'h00);
		add_row(OP_WR, A_CMD_STAT, 8'h80, 8'h00, 8'h00);
		add_row(OP_STREAM, 2'd0, 8'd3, 8'd0, 8'h00);
		add_row(OP_WAIT_INT, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h00, 8'h1D);
		add_row(OP_END, 2'd0, 8'd4, 8'h00, 8'h00);
		// ID for sector 9 never matches
		add_row(OP_WR, A_CMD_STAT, 8'h80, 8'h00, 8'h00);
		add_row(OP_STREAM, 2'd2, 8'd9, 8'd0, 8'h00);
		add_row(OP_WAIT_INT, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h10, 8'h10);
		add_row(OP_END, 2'd0, 8'd5, 8'h00, 8'h00);
		// first byte left unread
		add_row(OP_WR, A_CMD_STAT, 8'h80, 8'h00, 8'h00);
		add_row(OP_STREAM, 2'd1, 8'd3, 8'd0, 8'h00);
		add_row(OP_WAIT_INT, 2'd0, 8'h00, 8'h00, 8'h00);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h04, 8'h14);
		add_row(OP_END, 2'd0, 8'd6, 8'h00, 8'h00);
		// long slow seek, locked track write, then force interrupts
		add_row(OP_WR, A_DATA, 8'd200, 8'h00, 8'h00);
		add_row(OP_WR, A_CMD_STAT, 8'h13, 8'h00, 8'h00);
		add_row(OP_WR, A_TRACK, 8'h77, 8'h00, 8'h00);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h01, 8'h01);
		add_row(OP_WR, A_CMD_STAT, 8'hD0, 8'h00, 8'h00);
		add_row(OP_IDLE, 2'd0, 8'd200, 8'h00, 8'h00);
		add_row(OP_RDHEAD, A_TRACK, 8'h00, 8'h00, 8'hFF);
		add_row(OP_INTRQ, 2'd0, 8'h00, 8'h00, 8'hFF);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h00, 8'h01);
		add_row(OP_WR, A_CMD_STAT, 8'hD8, 8'h00, 8'h00);
		add_row(OP_INTRQ, 2'd0, 8'h00, 8'h01, 8'hFF);
		add_row(OP_RD, A_CMD_STAT, 8'h00, 8'h00, 8'h01);
		add_row(OP_INTRQ, 2'd0, 8'h00, 8'h00, 8'hFF);
		add_row(OP_END, 2'd0, 8'd7, 8'h00, 8'h00);
	endtask

	initial begin
		int i;
		arst_n     = 1'b0;
		cs_n       = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		addr       = 2'd0;
		din        = 8'h00;
		ms_tick    = 1'b0;
		trk00_n    = 1'b0;
		index_n    = 1'b1;
		id_valid   = 1'b0;
		id         = '0;
		byte_valid = 1'b0;
		byte_in    = 8'h00;
		seed       = 7;
		div_cnt    = 0;
		head_pos   = 0;
		in_cnt     = 0;
		out_cnt    = 0;
		tick_gap   = 0;
		min_gap    = 255;
		stuck      = 1'b0;
		err_total    = 0;
		test_err     = 0;
		tests_failed = 0;
		n_rows       = 0;
		test_name[0] = "reset defaults";
		test_name[1] = "seek";
		test_name[2] = "restore";
		test_name[3] = "restore seek error";
		test_name[4] = "read sector";
		test_name[5] = "record not found";
		test_name[6] = "lost data";
		test_name[7] = "force interrupt and locks";
		build_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (i = 0; i < n_rows; i++)
			apply_row(rows[i]);
		$display("%0d tests, %0d failed, %0d errors", 8, tests_failed, err_total);
		if (err_total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
rtl/fdc_pkg.sv
rtl/fdc_host_regs.sv
rtl/fdc_step_timer.sv
rtl/fdc_seek_fsm.sv
rtl/fdc_read_path.sv
rtl/fdc_top.sv
bench/fdc_tb.sv
